// File: files.f
source/ppu_mem_pkg.sv
source/ppu_video_pkg.sv
source/palette_loader.sv
source/line_fetcher.sv
source/pixel_output.sv
source/ppu_top.sv
tests/ppu_mem_model.sv
tests/ppu_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run from the project root so the stim file path resolves
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal --top-module ppu_tb -f files.f -o ppu_sim \
    || { echo "Build failed"; exit 1; }
./obj_dir/ppu_sim 2>&1 | tee sim.log
grep -qx "Verification passed" sim.log && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

// File: source/line_fetcher.sv
`timescale 1ns/1ps

module line_fetcher #(
    parameter int tiles_per_line = 40
) (
    input  logic                                         clk,
    input  logic                                         reset,
    input  ppu_video_pkg::video_pos_t                    pos,
    output ppu_mem_pkg::map_req_t                        map_req,
    input  logic [ppu_mem_pkg::word_w-1:0]               map_data,
    output ppu_mem_pkg::gfx_req_t                        gfx_req,
    input  logic [ppu_mem_pkg::word_w-1:0]               gfx_data,
    output ppu_video_pkg::line_tile_t [tiles_per_line-1:0] line_buf
);

    localparam int cnt_w          = $clog2(tiles_per_line + 1);
    localparam int map_aw         = ppu_mem_pkg::map_addr_w;
    localparam int gfx_aw         = ppu_mem_pkg::gfx_addr_w;
    localparam int ids            = ppu_video_pkg::ids_per_word;
    localparam int words_per_line = tiles_per_line / ids;
    localparam int field_w        = ppu_mem_pkg::word_w / ids;  // One byte per tile

    ppu_video_pkg::fetch_state_t state;

    logic             active;       // Line fetch window
    logic [cnt_w-1:0] cnt;          // Cycle count within fetch_run
    logic [cnt_w-1:0] gfx_tile;     // Tile whose row is requested now
    logic [1:0]       field;        // Byte of the map word for gfx_tile
    logic             map_pend;     // Map word arrives this cycle
    logic [ppu_mem_pkg::word_w-1:0] map_word;
    logic [ppu_mem_pkg::word_w-1:0] cur_word;
    logic [ppu_video_pkg::tile_id_w-1:0] cur_id;
    logic             cur_pal;
    logic             gfx_pend;     // Graphics row arrives this cycle
    logic [cnt_w-1:0] gfx_tile_d;
    logic             gfx_pal_d;

    assign active = pos.hsync && !pos.vblank;

    // Map word w is read at cnt 4w and its tiles go out at cnt 4w+1 .. 4w+4
    assign map_req.en = (state == ppu_video_pkg::fetch_run) && active
                        && (cnt < cnt_w'(tiles_per_line)) && (cnt % ids == 0);
    assign map_req.addr = map_aw'((pos.vcount / ppu_video_pkg::tile_px) * words_per_line
                                  + cnt / ids);

    assign gfx_tile = cnt - 1'b1;
    assign field    = 2'(gfx_tile % ids);
    assign cur_word = map_pend ? map_data : map_word;  // Fresh word bypasses the hold
    assign cur_id   = cur_word[field * field_w +: ppu_video_pkg::tile_id_w];
    assign cur_pal  = cur_word[field * field_w + field_w - 1];

    assign gfx_req.en   = (state == ppu_video_pkg::fetch_run) && active && (cnt != '0);
    assign gfx_req.addr = gfx_aw'(cur_id * ppu_video_pkg::tile_px
                                  + pos.vcount % ppu_video_pkg::tile_px);

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= ppu_video_pkg::fetch_idle;
            cnt      <= '0;
            map_pend <= 1'b0;
            gfx_pend <= 1'b0;
            line_buf <= '0;
        end else begin
            map_pend <= map_req.en;
            gfx_pend <= gfx_req.en;

            case (state)
                ppu_video_pkg::fetch_idle: begin
                    cnt <= '0;
                    if (active) begin
                        state <= ppu_video_pkg::fetch_run;
                    end
                end
                ppu_video_pkg::fetch_run: begin
                    if (!active) begin
                        state <= ppu_video_pkg::fetch_idle;
                    end else if (cnt == cnt_w'(tiles_per_line)) begin
                        state <= ppu_video_pkg::fetch_done;  // Last row request went out
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                ppu_video_pkg::fetch_done: begin
                    if (!active) begin
                        state <= ppu_video_pkg::fetch_idle;
                    end
                end
                default: state <= ppu_video_pkg::fetch_idle;
            endcase

            // Returned row lands in the entry it was requested for
            if (gfx_pend) begin
                line_buf[gfx_tile_d].row     <= gfx_data;
                line_buf[gfx_tile_d].pal_sel <= gfx_pal_d;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (map_pend) begin
            map_word <= map_data;  // Held for the remaining three tiles
        end
        gfx_tile_d <= gfx_tile;
        gfx_pal_d  <= cur_pal;
    end

endmodule

// File: source/palette_loader.sv
`timescale 1ns/1ps

module palette_loader #(
    parameter int palette_entries = 8
) (
    input  logic                            clk,
    input  logic                            reset,
    input  ppu_video_pkg::video_pos_t       pos,
    output ppu_mem_pkg::pal_req_t           pal_req,
    input  logic [ppu_mem_pkg::color_w-1:0] pal_data,
    output logic [ppu_mem_pkg::color_w-1:0] pal_buf [palette_entries]
);

    localparam int cnt_w  = $clog2(palette_entries + 1);
    localparam int pal_aw = ppu_mem_pkg::pal_addr_w;

    logic [cnt_w-1:0]  load_cnt;  // Next palette entry to request
    logic              rd_pend;   // A read returns data this cycle
    logic [pal_aw-1:0] rd_idx;

    // One read per cycle from the first vblank cycle
    assign pal_req.en   = pos.vblank && (load_cnt < cnt_w'(palette_entries));
    assign pal_req.addr = pal_aw'(load_cnt);

    always_ff @(posedge clk) begin
        if (reset) begin
            load_cnt <= '0;
            rd_pend  <= 1'b0;
            for (int i = 0; i < palette_entries; i++) begin
                pal_buf[i] <= '0;
            end
        end else begin
            rd_pend <= pal_req.en;

            if (pal_req.en) begin
                load_cnt <= load_cnt + 1'b1;
            end else if (!pos.vblank) begin
                load_cnt <= '0;  // Ready for the next frame
            end

            // Color arrives one cycle after its request
            if (rd_pend) begin
                pal_buf[rd_idx] <= pal_data;
            end
        end
    end

    // Entry index follows its read by one cycle
    always_ff @(posedge clk) begin
        rd_idx <= pal_req.addr;
    end

endmodule

// File: source/pixel_output.sv
`timescale 1ns/1ps

module pixel_output #(
    parameter int tiles_per_line  = 40,
    parameter int palette_entries = 8
) (
    input  logic                                         clk,
    input  logic                                         reset,
    input  ppu_video_pkg::video_pos_t                    pos,
    input  ppu_video_pkg::line_tile_t [tiles_per_line-1:0] line_buf,
    input  logic [ppu_mem_pkg::color_w-1:0]              pal_buf [palette_entries],
    output logic [ppu_mem_pkg::color_w-1:0]              pixel_color
);

    localparam int pal_iw = $clog2(palette_entries);

    logic [5:0]                tile_idx;
    logic [3:0]                px_idx;
    ppu_video_pkg::line_tile_t cur_tile;
    logic                      blank;

    logic              s1_blank;
    logic [1:0]        s1_code;
    logic              s1_pal_sel;
    logic [pal_iw-1:0] pal_idx;

    assign tile_idx = pos.hcount[10:5];
    assign px_idx   = pos.hcount[4:1];  // Drop bit 0 so each pixel shows twice
    assign cur_tile = line_buf[tile_idx];

    // Columns past the last tile show as border
    assign blank = pos.hsync || pos.vblank || (tile_idx >= 6'(tiles_per_line));

    // Code plus four times the palette bit
    assign pal_idx = pal_iw'({s1_pal_sel, s1_code});

    always_ff @(posedge clk) begin
        if (reset) begin
            s1_blank    <= 1'b1;
            pixel_color <= '0;
        end else begin
            s1_blank    <= blank;
            pixel_color <= s1_blank ? '0 : pal_buf[pal_idx];
        end
    end

    // Stage 1 payload
    always_ff @(posedge clk) begin
        s1_code    <= cur_tile.row[{px_idx, 1'b0} +: 2];
        s1_pal_sel <= cur_tile.pal_sel;
    end

endmodule

// File: source/ppu_mem_pkg.sv
package ppu_mem_pkg;

    // Memory widths
    parameter int map_addr_w = 9;   // Tile map holds 10 words per tile row
    parameter int gfx_addr_w = 11;  // Tile graphics hold 16 rows per tile
    parameter int pal_addr_w = 3;
    parameter int word_w     = 32;
    parameter int color_w    = 24;  // 8 bits each of red, green, blue

    // Fixed-latency read requests return data one cycle after en
    typedef struct packed {
        logic                  en;
        logic [map_addr_w-1:0] addr;
    } map_req_t;

    typedef struct packed {
        logic                  en;
        logic [gfx_addr_w-1:0] addr;
    } gfx_req_t;

    typedef struct packed {
        logic                  en;
        logic [pal_addr_w-1:0] addr;
    } pal_req_t;

endpackage

// File: source/ppu_top.sv
`timescale 1ns/1ps

module ppu_top #(
    parameter int tiles_per_line  = 40,
    parameter int palette_entries = 8
) (
    input  logic                            clk,
    input  logic                            reset,
    input  ppu_video_pkg::video_pos_t       pos,
    output ppu_mem_pkg::map_req_t           map_req,
    input  logic [ppu_mem_pkg::word_w-1:0]  map_data,
    output ppu_mem_pkg::gfx_req_t           gfx_req,
    input  logic [ppu_mem_pkg::word_w-1:0]  gfx_data,
    output ppu_mem_pkg::pal_req_t           pal_req,
    input  logic [ppu_mem_pkg::color_w-1:0] pal_data,
    output logic [ppu_mem_pkg::color_w-1:0] pixel_color
);

    logic [ppu_mem_pkg::color_w-1:0] pal_buf [palette_entries];
    ppu_video_pkg::line_tile_t [tiles_per_line-1:0] line_buf;

    // Refilled every vblank
    palette_loader #(.palette_entries(palette_entries)) u_palette_loader (
        .clk     (clk),
        .reset   (reset),
        .pos     (pos),
        .pal_req (pal_req),
        .pal_data(pal_data),
        .pal_buf (pal_buf)
    );

    // Background line built during hsync
    line_fetcher #(.tiles_per_line(tiles_per_line)) u_line_fetcher (
        .clk     (clk),
        .reset   (reset),
        .pos     (pos),
        .map_req (map_req),
        .map_data(map_data),
        .gfx_req (gfx_req),
        .gfx_data(gfx_data),
        .line_buf(line_buf)
    );

    pixel_output #(
        .tiles_per_line (tiles_per_line),
        .palette_entries(palette_entries)
    ) u_pixel_output (
        .clk        (clk),
        .reset      (reset),
        .pos        (pos),
        .line_buf   (line_buf),
        .pal_buf    (pal_buf),
        .pixel_color(pixel_color)
    );

endmodule

// File: source/ppu_video_pkg.sv
package ppu_video_pkg;

    // Screen geometry
    parameter int tile_px      = 16;  // Pixels per tile side
    parameter int ids_per_word = 4;   // Tile IDs packed in one map word
    parameter int tile_id_w    = 7;

    // Timing inputs from the VGA controller
    typedef struct packed {
        logic [10:0] hcount;
        logic [9:0]  vcount;
        logic        vblank;
        logic        hsync;
    } video_pos_t;

    // One background tile of the current line
    typedef struct packed {
        logic [ppu_mem_pkg::word_w-1:0] row;  // 16 pixels at 2 bits each
        logic                           pal_sel;
    } line_tile_t;

    typedef enum logic [1:0] {
        fetch_idle,
        fetch_run,
        fetch_done
    } fetch_state_t;

endpackage

// File: tests/ppu_mem_model.sv
`timescale 1ns/1ps

module ppu_mem_model #(
    parameter int addr_w = 9,
    parameter int data_w = 32
) (
    input  logic              clk,
    input  logic              en,
    input  logic [addr_w-1:0] addr,
    output logic [data_w-1:0] data
);

    logic [data_w-1:0] mem [2**addr_w];  // Loaded by the testbench

    initial data = '0;

    // Data follows en by one cycle and never stalls
    always @(posedge clk) begin
        if (en) begin
            data <= mem[addr];
        end
    end

endmodule

// File: tests/ppu_stim.txt
// Hex words. @00 palette colors, @08 map count then (addr data), @10 graphics count then
// (addr data), @18 line count then vcounts, @20 check count then (vcount hcount color)
@00
101010 FF0000 00FF00 0000FF
202020 FFFF00 00FFFF FF00FF
@08
002
000 00008201
015 03000081
@10
003
015 000000E4
025 FFFF0000
035 80000000
@18
003 005 025 0C8
@20
00A
005 000 101010
005 003 FF0000
005 006 0000FF
005 009 101010
005 020 202020
005 031 FF00FF
025 082 FFFF00
025 085 00FFFF
025 0E0 101010
025 0FE 00FF00

// File: tests/ppu_tb.sv
`timescale 1ns/1ps

module ppu_tb;

    localparam int hsync_len  = 64;
    localparam int active_len = 1280;  // 40 tiles of 32 doubled pixels
    localparam int vblank_len = 20;
    localparam int rand_pts   = 16;    // Random hcount checks per line

    typedef struct packed {
        logic                            check;
        logic [ppu_mem_pkg::color_w-1:0] color;
    } pixel_exp_t;

    logic                            clk = 1'b0;
    logic                            reset;
    ppu_video_pkg::video_pos_t       pos;
    ppu_mem_pkg::map_req_t           map_req;
    ppu_mem_pkg::gfx_req_t           gfx_req;
    ppu_mem_pkg::pal_req_t           pal_req;
    logic [ppu_mem_pkg::word_w-1:0]  map_data;
    logic [ppu_mem_pkg::word_w-1:0]  gfx_data;
    logic [ppu_mem_pkg::color_w-1:0] pal_data;
    logic [ppu_mem_pkg::color_w-1:0] pixel_color;

    logic [31:0] stim [64];
    pixel_exp_t  line_exp [active_len];  // Points checked on the current line
    pixel_exp_t  pipe1;
    pixel_exp_t  pipe2;
    int errors = 0;
    int checks = 0;
    int cycles = 0;
    int cycle_limit = 0;
    int map_cnt = 0;
    int gfx_cnt = 0;
    int pal_cnt = 0;

    always #2 clk = ~clk;

    ppu_top #(
        .tiles_per_line (40),
        .palette_entries(8)
    ) uut (
        .clk        (clk),
        .reset      (reset),
        .pos        (pos),
        .map_req    (map_req),
        .map_data   (map_data),
        .gfx_req    (gfx_req),
        .gfx_data   (gfx_data),
        .pal_req    (pal_req),
        .pal_data   (pal_data),
        .pixel_color(pixel_color)
    );

    ppu_mem_model #(.addr_w(ppu_mem_pkg::map_addr_w), .data_w(32)) map_mem (
        .clk(clk), .en(map_req.en), .addr(map_req.addr), .data(map_data)
    );
    ppu_mem_model #(.addr_w(ppu_mem_pkg::gfx_addr_w), .data_w(32)) gfx_mem (
        .clk(clk), .en(gfx_req.en), .addr(gfx_req.addr), .data(gfx_data)
    );
    ppu_mem_model #(.addr_w(ppu_mem_pkg::pal_addr_w), .data_w(24)) pal_mem (
        .clk(clk), .en(pal_req.en), .addr(pal_req.addr), .data(pal_data)
    );

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string msg);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Fail at %0t: %s, got %h, expected %h", $time, msg, actual, expected);
        end
    endtask

    // Row address of one tile from the byte field of its map word
    function automatic int gfx_addr_ref(input int v, input int tile);
        logic [31:0] word;
        word = map_mem.mem[(v / 16) * 10 + tile / 4];
        return word[8 * (tile % 4) +: 7] * 16 + v % 16;
    endfunction

    function automatic logic [23:0] pixel_ref(input int v, input int h);
        int          tile;
        int          px;
        logic [31:0] word;
        logic [31:0] row;
        tile = h / 32;
        px   = (h % 32) / 2;  // Two hcount steps per pixel
        word = map_mem.mem[(v / 16) * 10 + tile / 4];
        row  = gfx_mem.mem[gfx_addr_ref(v, tile)];
        return pal_mem.mem[row[2 * px +: 2] + 4 * word[8 * (tile % 4) + 7]];
    endfunction

    // Address patterns first and then the entries from the stim file
    task automatic fill_memories();
        for (int a = 0; a < 512; a++) begin
            map_mem.mem[a] = (a * 32'h9e37_79b9) ^ 32'h0f1e_2d3c;
        end
        for (int a = 0; a < 2048; a++) begin
            gfx_mem.mem[a] = (a * 32'h0100_0193) ^ {a[15:0], ~a[15:0]};
        end
        for (int i = 0; i < 8; i++) begin
            pal_mem.mem[i] = stim[i][23:0];
        end
        for (int i = 0; i < stim[8'h08]; i++) begin
            map_mem.mem[stim[8'h09 + 2 * i][8:0]] = stim[8'h0a + 2 * i];
        end
        for (int i = 0; i < stim[8'h10]; i++) begin
            gfx_mem.mem[stim[8'h11 + 2 * i][10:0]] = stim[8'h12 + 2 * i];
        end
    endtask

    task automatic render_line(input logic [9:0] v);
        int h;
        for (int i = 0; i < active_len; i++) begin
            line_exp[i] = '0;
        end
        for (int i = 0; i < stim[8'h20]; i++) begin
            if (stim[8'h21 + 3 * i][9:0] == v) begin
                line_exp[stim[8'h22 + 3 * i]] = {1'b1, stim[8'h23 + 3 * i][23:0]};
            end
        end
        for (int i = 0; i < rand_pts; i++) begin
            h = $urandom % active_len;
            if (!line_exp[h].check) begin
                line_exp[h] = {1'b1, pixel_ref(v, h)};
            end
        end
        map_cnt = 0;
        gfx_cnt = 0;
        pos.vcount <= v;
        pos.hcount <= '0;
        pos.hsync  <= 1'b1;
        repeat (hsync_len) @(posedge clk);
        check_value(map_cnt, 10, "map reads in hsync");
        check_value(gfx_cnt, 40, "graphics reads in hsync");
        pos.hsync <= 1'b0;
        for (int i = 0; i < active_len; i++) begin
            pos.hcount <= 11'(i);
            @(posedge clk);
        end
    endtask

    // Expected pixels trail the inputs by two cycles
    always @(negedge clk) begin
        pixel_exp_t cur;
        if (!reset) begin
            if (pipe2.check) begin
                check_value(pixel_color, pipe2.color, "pixel color");
            end
            cur.check = pos.hsync || pos.vblank;  // Blanked pixels read zero
            cur.color = '0;
            if (!cur.check && line_exp[pos.hcount].check === 1'b1) begin
                cur = line_exp[pos.hcount];
            end
            pipe2 = pipe1;
            pipe1 = cur;
            if (pal_req.en) begin
                check_value(pal_req.addr, pal_cnt, "palette address");
                pal_cnt++;
            end
            if (map_req.en) begin
                check_value(map_req.addr, (pos.vcount / 16) * 10 + map_cnt, "map address");
                map_cnt++;
            end
            if (gfx_req.en) begin
                check_value(gfx_req.addr, gfx_addr_ref(pos.vcount, gfx_cnt), "graphics address");
                gfx_cnt++;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("Timeout after %0d cycles, the run did not finish", cycles);
            $display("Verification failed");
            $finish;
        end
    end

    initial begin
        void'($urandom(32'hbeb0));
        $readmemh("tests/ppu_stim.txt", stim);
        cycle_limit = (stim[8'h18] * (hsync_len + 1300) + vblank_len) * 5 / 4;
        pos       = '0;
        pos.hsync = 1'b1;  // Open fetch window that only reset keeps idle
        reset     = 1'b1;
        pipe1     = '0;
        pipe2     = '0;
        fill_memories();
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_value(map_req.en, 0, "map request after reset");
        check_value(gfx_req.en, 0, "graphics request after reset");
        check_value(pal_req.en, 0, "palette request after reset");
        check_value(pixel_color, 0, "pixel color after reset");
        @(posedge clk);
        pal_cnt = 0;
        pos.hsync  <= 1'b0;
        pos.vblank <= 1'b1;
        repeat (vblank_len) @(posedge clk);
        pos.vblank <= 1'b0;
        check_value(pal_cnt, 8, "palette reads in vblank");
        for (int l = 0; l < stim[8'h18]; l++) begin
            render_line(stim[8'h19 + l][9:0]);
        end
        repeat (2) @(posedge clk);  // Last pixels drain
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule
